/* Makefile */
VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
rtl/cachePkg.sv
rtl/cacheIfs.sv
rtl/cacheArray.sv
rtl/busBeats.sv
rtl/cacheController.sv
rtl/cacheTop.sv
tests/cacheController_asserts.sv
tests/cacheChecker.sv
tests/cacheTb.sv

/* rtl/busBeats.sv */
// Bus beat engine: beat counter, beat address, fetch buffer and writeback data
module busBeats import cachePkg::*; (
  input  logic               clk,
  input  logic               reset,
  beatIf.engine              beat,
  output logic               busRead,
  output logic               busWrite,
  output logic [PA_BITS-1:0] busAdr,
  output logic [WORD_BITS-1:0] busWriteData,
  input  logic [WORD_BITS-1:0] busReadData,
  input  logic               busAck
);

  logic                     active;     // Burst in progress
  logic                     isRead;     // Fetch, else writeback
  logic [WORD_IDX_BITS-1:0] cnt;        // Current beat
  logic                     doneQ;
  lineT                     fetchBuf;
  paAddrT                   beatAdr;

  //////////////////////////////
  // Beat sequencing
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      isRead <= 1'b0;
      cnt    <= '0;
      doneQ  <= 1'b0;
    end else begin
      doneQ <= 1'b0;
      if (!active) begin
        if (beat.fetchStart | beat.writebackStart) begin
          active <= 1'b1;
          isRead <= beat.fetchStart;
          cnt    <= '0;
        end
      end else if (busAck) begin
        cnt <= cnt + 1'b1;
        if (&cnt) begin             // Fourth acknowledge
          active <= 1'b0;
          doneQ  <= 1'b1;
        end
      end
    end
  end

  // Capture each returned read beat
  always_ff @(posedge clk) begin
    if (active & isRead & busAck) fetchBuf[cnt*WORD_BITS +: WORD_BITS] <= busReadData;
  end

  //////////////////////////////
  // Bus side
  //////////////////////////////
  always_comb begin
    beatAdr           = beat.lineAdr;
    beatAdr.f.wordIdx = cnt;          // Words go out in order
    beatAdr.f.byteOff = '0;
  end

  assign busRead        = active & isRead;   // Held until the burst ends
  assign busWrite       = active & ~isRead;
  assign busAdr         = beatAdr.flat;
  assign busWriteData   = beat.writeLine[cnt*WORD_BITS +: WORD_BITS];
  assign beat.beatsDone = doneQ;
  assign beat.fetchLine = fetchBuf;

endmodule

/* rtl/cacheArray.sv */
// Direct mapped storage: data, tag, valid and dirty arrays with registered lookup
module cacheArray import cachePkg::*; (
  input logic   clk,
  input logic   reset,
  arrayIf.array arr
);

  lineT                 dataArr [NUM_LINES];
  logic [TAG_BITS-1:0]  tagArr  [NUM_LINES];
  logic [NUM_LINES-1:0] validBits, dirtyBits;
  logic [SET_BITS-1:0]  setQ;     // Registered lookup index
  logic [TAG_BITS-1:0]  tagQ;     // Registered request tag
  lineT                 readLine;

  //////////////////////////////
  // Lookup
  //////////////////////////////
  always_ff @(posedge clk) begin
    setQ <= arr.set;     // Synchronous read, one cycle after the index
    tagQ <= arr.newTag;
  end

  assign readLine      = dataArr[setQ];
  assign arr.readLine  = readLine;
  assign arr.readWord  = readLine[arr.wordSel*WORD_BITS +: WORD_BITS];
  assign arr.victimTag = tagArr[setQ];
  assign arr.hit       = validBits[setQ] & (tagArr[setQ] == tagQ);
  assign arr.lineDirty = validBits[setQ] & dirtyBits[setQ];  // Stale dirty ignored once invalid

  //////////////////////////////
  // Status bits
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (arr.invalidateAll) begin
      validBits <= '0;                 // Dirty left alone, masked by valid
    end else if (arr.lineWrite) begin
      validBits[arr.set] <= 1'b1;
      dirtyBits[arr.set] <= 1'b0;      // Fresh refill or line just written back
    end else if (arr.wordWrite) begin
      dirtyBits[arr.set] <= 1'b1;
    end
  end

  //////////////////////////////
  // Data and tags
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (arr.lineWrite) begin
      dataArr[arr.set] <= arr.lineData;
      tagArr[arr.set]  <= arr.newTag;
    end else if (arr.wordWrite) begin
      // Only enabled bytes of the selected word change
      for (int b = 0; b < WORD_BITS/8; b++) begin
        if (arr.byteMask[b])
          dataArr[arr.set][arr.wordSel*WORD_BITS + b*8 +: 8] <= arr.writeData[b*8 +: 8];
      end
    end
  end

endmodule

/* rtl/cacheController.sv */
// Cache FSM: hit and miss handling, writeback, refill, store merge, flush walk, invalidate
module cacheController import cachePkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cacheReq,
  input  logic                   cacheWrite,
  input  logic [PA_BITS-1:0]     cacheAdr,
  input  logic [WORD_BITS/8-1:0] byteMask,
  input  logic [WORD_BITS-1:0]   writeData,
  input  logic                   flushCache,
  input  logic                   invalidateCache,
  output logic                   cacheBusy,
  output logic                   cacheDone,
  output logic                   cacheMiss,
  output logic [WORD_BITS-1:0]   readDataWord,
  arrayIf.ctrl                   arr,
  beatIf.ctrl                    beat
);

  ctrlStateT                state, nextState;
  paAddrT                   inAdr, reqAdr;     // Incoming and latched request address
  logic                     reqWrite;
  logic [WORD_BITS/8-1:0]   reqMask;
  logic [WORD_BITS-1:0]     reqData;
  logic [SET_BITS-1:0]      flushSet;          // Flush walk position
  logic                     accept, finish, flushing;

  assign inAdr.flat = cacheAdr;
  assign accept     = (state == Idle) & ~cacheDone;  // Nothing taken in the done cycle
  assign flushing   = (state == FlushCheck) | (state == FlushWrite);

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    nextState = state;
    finish    = 1'b0;
    case (state)
      Idle: begin
        if (accept) begin
          if (flushCache)           nextState = FlushCheck;
          else if (invalidateCache) nextState = Invalidate;
          else if (cacheReq)        nextState = Lookup;
        end
      end
      Lookup: begin
        if (arr.hit) begin
          nextState = Idle;
          finish    = 1'b1;
        end else if (arr.lineDirty) nextState = Writeback;  // Victim out first
        else                        nextState = Fetch;
      end
      Writeback:  if (beat.beatsDone) nextState = Fetch;
      Fetch:      if (beat.beatsDone) nextState = Refill;
      Refill:     nextState = Lookup;   // Relookup hits, store merges there
      FlushCheck: begin
        if (arr.lineDirty) nextState = FlushWrite;
        else if (&flushSet) begin
          nextState = Idle;
          finish    = 1'b1;
        end
      end
      FlushWrite: if (beat.beatsDone) nextState = FlushCheck;  // Same set, now clean
      Invalidate: begin
        nextState = Idle;
        finish    = 1'b1;
      end
      default:    nextState = Idle;
    endcase
  end

  //////////////////////////////
  // State and request registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= Idle;
      cacheDone <= 1'b0;
      flushSet  <= '0;
    end else begin
      state     <= nextState;
      cacheDone <= finish;
      if (state == Idle) flushSet <= '0;
      else if ((state == FlushCheck) & ~arr.lineDirty) flushSet <= flushSet + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept & cacheReq) begin
      reqAdr   <= inAdr;
      reqWrite <= cacheWrite;
      reqMask  <= byteMask;
      reqData  <= writeData;
    end
    if ((state == Lookup) & arr.hit) readDataWord <= arr.readWord;  // Valid with cacheDone
  end

  assign cacheBusy = (state != Idle) | cacheDone;
  assign cacheMiss = (state == Lookup) & ~arr.hit;

  //////////////////////////////
  // Array control
  //////////////////////////////
  always_comb begin
    case (state)
      Idle:       arr.set = flushCache ? '0 : inAdr.f.set;   // Index ahead of the lookup
      FlushCheck: arr.set = arr.lineDirty ? flushSet : flushSet + 1'b1;
      FlushWrite: arr.set = flushSet;
      default:    arr.set = reqAdr.f.set;
    endcase
  end

  assign arr.wordSel       = reqAdr.f.wordIdx;
  assign arr.newTag        = (state == Idle) ? inAdr.f.tag :
                             flushing        ? arr.victimTag : reqAdr.f.tag;  // Flush keeps tag
  assign arr.lineWrite     = (state == Refill) | ((state == FlushWrite) & beat.beatsDone);
  assign arr.lineData      = (state == Refill) ? beat.fetchLine : arr.readLine;
  assign arr.wordWrite     = (state == Lookup) & arr.hit & reqWrite;
  assign arr.byteMask      = reqMask;
  assign arr.writeData     = reqData;
  assign arr.invalidateAll = (state == Invalidate);

  //////////////////////////////
  // Beat engine control
  //////////////////////////////
  assign beat.writebackStart = ((state == Lookup) & ~arr.hit & arr.lineDirty)
                             | ((state == FlushCheck) & arr.lineDirty);
  assign beat.fetchStart     = ((state == Lookup) & ~arr.hit & ~arr.lineDirty)
                             | ((state == Writeback) & beat.beatsDone);
  assign beat.writeLine      = arr.readLine;   // Array is quiet during writeback

  always_comb begin
    beat.lineAdr.f.tag     = (state == Fetch) ? reqAdr.f.tag : arr.victimTag;
    beat.lineAdr.f.set     = arr.set;
    beat.lineAdr.f.wordIdx = '0;
    beat.lineAdr.f.byteOff = '0;
  end

endmodule

/* rtl/cacheIfs.sv */
// Array interface and bus beat interface, each with a controller modport
interface arrayIf import cachePkg::*; ();
  logic [SET_BITS-1:0]      set;            // Index for lookup and writes
  logic [WORD_IDX_BITS-1:0] wordSel;        // Word within the line
  logic                     lineWrite;      // Whole line write, valid set, dirty cleared
  logic                     wordWrite;      // Masked word write, dirty set
  logic [WORD_BITS/8-1:0]   byteMask;
  logic [WORD_BITS-1:0]     writeData;
  lineT                     lineData;       // Line to store on lineWrite
  logic [TAG_BITS-1:0]      newTag;         // Request tag, also tag written on lineWrite
  logic                     invalidateAll;
  logic                     hit;
  logic                     lineDirty;      // Valid and dirty at the looked up set
  logic [TAG_BITS-1:0]      victimTag;
  lineT                     readLine;
  logic [WORD_BITS-1:0]     readWord;

  modport ctrl  (output set, wordSel, lineWrite, wordWrite, byteMask, writeData, lineData,
                 newTag, invalidateAll,
                 input  hit, lineDirty, victimTag, readLine, readWord);
  modport array (input  set, wordSel, lineWrite, wordWrite, byteMask, writeData, lineData,
                 newTag, invalidateAll,
                 output hit, lineDirty, victimTag, readLine, readWord);
endinterface

interface beatIf import cachePkg::*; ();
  logic   fetchStart, writebackStart;  // Strobes
  paAddrT lineAdr;                     // Line base address, offset bits zero
  lineT   writeLine;                   // Victim line for writeback
  logic   beatsDone;                   // Pulse after the last acknowledge
  lineT   fetchLine;                   // Fetch buffer

  modport ctrl   (output fetchStart, writebackStart, lineAdr, writeLine,
                  input  beatsDone, fetchLine);
  modport engine (input  fetchStart, writebackStart, lineAdr, writeLine,
                  output beatsDone, fetchLine);
endinterface

/* rtl/cachePkg.sv */
// Cache geometry constants, physical address union, line type and controller states
package cachePkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////
  localparam int PA_BITS        = 16;  // Physical address width
  localparam int WORD_BITS      = 32;  // CPU word and bus beat width
  localparam int WORDS_PER_LINE = 4;   // One beat per word
  localparam int NUM_LINES      = 16;  // Direct mapped, one line per set
  localparam int SET_BITS       = 4;
  localparam int WORD_IDX_BITS  = 2;
  localparam int BYTE_BITS      = 2;
  localparam int TAG_BITS       = PA_BITS - SET_BITS - WORD_IDX_BITS - BYTE_BITS;  // 8

  // Field view of an address, msb first
  typedef struct packed {
    logic [TAG_BITS-1:0]      tag;
    logic [SET_BITS-1:0]      set;
    logic [WORD_IDX_BITS-1:0] wordIdx;
    logic [BYTE_BITS-1:0]     byteOff;
  } paFieldsT;

  // Same address word seen flat (bus side) or split (lookup side)
  typedef union packed {
    logic [PA_BITS-1:0] flat;
    paFieldsT           f;
  } paAddrT;

  typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] lineT;  // Word 0 in the low bits

  typedef enum logic [2:0] {
    Idle, Lookup, Writeback, Fetch, Refill, FlushCheck, FlushWrite, Invalidate
  } ctrlStateT;

endpackage

/* rtl/cacheTop.sv */
// Top level cache subsystem: array, bus beat engine and controller joined by two interfaces
module cacheTop import cachePkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  // CPU side
  input  logic                   cacheReq,
  input  logic                   cacheWrite,
  input  logic [PA_BITS-1:0]     cacheAdr,
  input  logic [WORD_BITS/8-1:0] byteMask,
  input  logic [WORD_BITS-1:0]   writeData,
  input  logic                   flushCache,
  input  logic                   invalidateCache,
  output logic                   cacheBusy,
  output logic                   cacheDone,
  output logic [WORD_BITS-1:0]   readDataWord,
  output logic                   cacheMiss,
  // Memory bus side
  output logic                   busRead,
  output logic                   busWrite,
  output logic [PA_BITS-1:0]     busAdr,
  output logic [WORD_BITS-1:0]   busWriteData,
  input  logic [WORD_BITS-1:0]   busReadData,
  input  logic                   busAck
);

  arrayIf arrBus ();   // Controller to storage
  beatIf  beatBus ();  // Controller to beat engine

  cacheArray array (.clk, .reset, .arr(arrBus.array));

  busBeats beats (
    .clk, .reset, .beat(beatBus.engine),
    .busRead, .busWrite, .busAdr, .busWriteData, .busReadData, .busAck
  );

  cacheController ctrl (
    .clk, .reset, .cacheReq, .cacheWrite, .cacheAdr, .byteMask, .writeData,
    .flushCache, .invalidateCache, .cacheBusy, .cacheDone, .cacheMiss, .readDataWord,
    .arr(arrBus.ctrl), .beat(beatBus.ctrl)
  );

endmodule

/* tests/cacheChecker.sv */
// Checker: shadow of the CPU view, mirror of bus memory, per-test compares and report lines
module cacheChecker import cachePkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cacheReq,
  input  logic                   cacheWrite,
  input  logic                   flushCache,
  input  logic                   invalidateCache,
  input  logic [PA_BITS-1:0]     cacheAdr,
  input  logic [WORD_BITS/8-1:0] byteMask,
  input  logic [WORD_BITS-1:0]   writeData,
  input  logic                   cacheBusy,
  input  logic                   cacheDone,
  input  logic                   cacheMiss,
  input  logic [WORD_BITS-1:0]   readDataWord,
  input  logic                   busRead,
  input  logic                   busWrite,
  input  logic                   busAck,
  input  logic [PA_BITS-1:0]     busAdr,
  input  logic [WORD_BITS-1:0]   busWriteData,
  input  logic [8*16-1:0]        testName,     // Current table entry
  input  logic                   expMiss,
  input  int                     expWbBeats,
  output int                     errorCount,
  output int                     testCount
);

  logic [WORD_BITS-1:0] shadow [2**(PA_BITS-2)];  // What a CPU read must return
  logic [WORD_BITS-1:0] mirror [2**(PA_BITS-2)];  // What bus memory must hold
  logic [8*16-1:0]      name;
  logic [WORD_BITS-1:0] expWord;
  logic                 isRead, isFlush, wantMiss, active;
  int                   wantWb, misses, rdBeats, wbBeats, cycles, errs;

  // Word index appears twice, so every word address gets its own value
  function automatic logic [WORD_BITS-1:0] fillWord(input logic [PA_BITS-3:0] w);
    return {w, 4'hA, w};
  endfunction

  task automatic compareValue(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch test %0s %0s expected %h actual %h", name, what, exp, act);
      errs++;
    end
  endtask

  initial begin
    for (int w = 0; w < 2**(PA_BITS-2); w++) begin
      shadow[w] = fillWord(w);
      mirror[w] = fillWord(w);
    end
  end

  //////////////////////////////
  // Watch at the falling edge
  //////////////////////////////
  always @(negedge clk) begin
    if (reset) begin
      errorCount = 0;
      testCount  = 0;
      active     = 1'b0;
    end else if (!cacheBusy && (cacheReq || flushCache || invalidateCache)) begin
      name     = testName;   // New test starts with the accepted strobe
      wantMiss = expMiss;
      wantWb   = expWbBeats;
      isRead   = cacheReq && !cacheWrite;
      isFlush  = flushCache;
      misses   = 0;
      rdBeats  = 0;
      wbBeats  = 0;
      cycles   = 0;
      errs     = 0;
      active   = 1'b1;
      if (cacheReq && cacheWrite) begin
        for (int b = 0; b < WORD_BITS/8; b++) begin
          if (byteMask[b]) shadow[cacheAdr[PA_BITS-1:2]][b*8 +: 8] = writeData[b*8 +: 8];
        end
      end
      expWord = shadow[cacheAdr[PA_BITS-1:2]];
    end else if (active) begin
      cycles++;
      if (cacheMiss) misses++;
      if (busRead && busAck) rdBeats++;
      if (busWrite && busAck) begin
        wbBeats++;
        compareValue("writeback data", shadow[busAdr[PA_BITS-1:2]], busWriteData);
        mirror[busAdr[PA_BITS-1:2]] = busWriteData;  // Memory now holds the beat
      end
      if (cacheDone) begin
        if (isRead) compareValue("read data", expWord, readDataWord);
        compareValue("miss pulses", wantMiss, misses);
        compareValue("read beats", wantMiss ? 4 : 0, rdBeats);   // Whole line on a miss
        compareValue("writeback beats", wantWb, wbBeats);
        if (!wantMiss && !isFlush) compareValue("done latency", 2, cycles);
        if (isFlush) begin
          // Nothing dirty left, memory equals the CPU view everywhere
          for (int w = 0; w < 2**(PA_BITS-2); w++) begin
            if (mirror[w] !== shadow[w]) compareValue("memory after flush", shadow[w], mirror[w]);
          end
        end
        $display("Test %0d %0s: %0s", testCount, name, (errs == 0) ? "ok" : "error");
        testCount++;
        errorCount += errs;
        active = 1'b0;
      end
    end
  end

endmodule

/* tests/cacheController_asserts.sv */
// Controller assertions: one burst at a time, busy held until done, two-cycle hit
module cacheControllerAsserts import cachePkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      cacheReq,
  input logic      flushCache,
  input logic      invalidateCache,
  input logic      cacheBusy,
  input logic      cacheDone,
  input ctrlStateT state,
  input logic      hit,
  input logic      fetchStart,
  input logic      writebackStart,
  input logic      beatsDone
);

  logic burstOpen;      // Start strobe seen, beatsDone still to come
  int   failCount = 0;  // Failed assertions so far

  always_ff @(posedge clk) begin
    if (reset)                             burstOpen <= 1'b0;
    else if (fetchStart || writebackStart) burstOpen <= 1'b1;
    else if (beatsDone)                    burstOpen <= 1'b0;
  end

  // New burst only once the last one ends, so bus read and write never overlap
  aOneBurst: assert property (@(posedge clk) disable iff (reset)
    (fetchStart || writebackStart) |-> (!burstOpen || beatsDone))
    else begin
      $error("burst started while another burst was still running");
      failCount++;
    end

  aDoneEndsBusy: assert property (@(posedge clk) disable iff (reset)
    cacheDone |-> $past(cacheBusy))
    else begin
      $error("cacheDone pulsed without a busy cycle before it");
      failCount++;
    end

  aBusyUntilDone: assert property (@(posedge clk) disable iff (reset)
    cacheBusy && !cacheDone |=> cacheBusy)
    else begin
      $error("cacheBusy dropped before cacheDone");
      failCount++;
    end

  // Accepted request that hits in its first lookup
  aHitTwoCycles: assert property (@(posedge clk) disable iff (reset)
    $past(cacheReq && !cacheBusy && !flushCache && !invalidateCache) && hit
      |=> cacheDone && (state == Idle))
    else begin
      $error("hit did not finish two cycles after the request");
      failCount++;
    end

endmodule

bind cacheController cacheControllerAsserts ctrlAsserts (
  .clk(clk), .reset(reset), .cacheReq(cacheReq), .flushCache(flushCache),
  .invalidateCache(invalidateCache), .cacheBusy(cacheBusy), .cacheDone(cacheDone),
  .state(state), .hit(arr.hit), .fetchStart(beat.fetchStart),
  .writebackStart(beat.writebackStart), .beatsDone(beat.beatsDone)
);

/* tests/cacheTb.sv */
// Testbench top: clock, reset, stimulus table, bus memory with random ack delay, timeout
module cacheTb import cachePkg::*; ();

  typedef enum logic [1:0] {OpRead, OpWrite, OpFlush, OpInval} opT;
  typedef struct {
    opT                     op;
    logic [PA_BITS-1:0]     adr;
    logic [WORD_BITS/8-1:0] mask;
    logic [WORD_BITS-1:0]   data;
    logic                   miss;   // Expected miss
    int                     wb;     // Expected bus write beats
    logic [8*16-1:0]        name;
  } entryT;

  logic                   clk, reset, cacheReq, cacheWrite, flushCache, invalidateCache;
  logic [PA_BITS-1:0]     cacheAdr, busAdr;
  logic [WORD_BITS/8-1:0] byteMask;
  logic [WORD_BITS-1:0]   writeData, readDataWord, busWriteData, busReadData;
  logic                   cacheBusy, cacheDone, cacheMiss, busRead, busWrite, busAck;
  logic [8*16-1:0]        testName;
  logic                   expMiss;
  int                     expWbBeats, errorCount, testCount;
  int                     cycleCount = 0;
  int                     cycleLimit = 0;
  int                     beatWait = 0;     // Cycles left before the ack
  logic [31:0]            rngState = 32'h3f95531a;
  logic [WORD_BITS-1:0]   mem [2**(PA_BITS-2)];
  entryT                  stim [$];

  cacheTop     DUT   (.*);
  cacheChecker check (.*);

  function automatic logic [WORD_BITS-1:0] fillWord(input logic [PA_BITS-3:0] w);
    return {w, 4'hA, w};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Bus memory model
  //////////////////////////////
  always @(posedge clk) begin
    #10;
    busAck = 1'b0;
    if (!reset && (busRead || busWrite)) begin
      if (beatWait == 0) begin          // New beat, pick its delay
        rngState = xorshift(rngState);
        beatWait = 1 + rngState[1:0];
      end
      beatWait--;
      if (beatWait == 0) begin
        busAck = 1'b1;
        if (busWrite) mem[busAdr[PA_BITS-1:2]] = busWriteData;
        else busReadData = mem[busAdr[PA_BITS-1:2]];
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    {reset, cacheReq, cacheWrite, flushCache, invalidateCache, busAck} = 6'b100000;
    {cacheAdr, byteMask, writeData, busReadData} = '0;
    {testName, expMiss, expWbBeats} = '0;
    for (int w = 0; w < 2**(PA_BITS-2); w++) mem[w] = fillWord(w);
    // Tag in [15:8], set in [7:4], word in [3:2]
    stim.push_back(entryT'{OpRead,  16'h1234, 4'h0, 32'h0,        1'b1, 0, "rdMiss"});
    stim.push_back(entryT'{OpRead,  16'h1234, 4'h0, 32'h0,        1'b0, 0, "rdHit"});
    stim.push_back(entryT'{OpRead,  16'h1238, 4'h0, 32'h0,        1'b0, 0, "rdHitWord2"});
    stim.push_back(entryT'{OpWrite, 16'h1234, 4'h5, 32'hdeadbeef, 1'b0, 0, "wrHitMask"});
    stim.push_back(entryT'{OpRead,  16'h1234, 4'h0, 32'h0,        1'b0, 0, "rdAfterWr"});
    stim.push_back(entryT'{OpWrite, 16'h2250, 4'hf, 32'h01234567, 1'b1, 0, "stMiss"});
    stim.push_back(entryT'{OpRead,  16'h2250, 4'h0, 32'h0,        1'b0, 0, "rdMerged"});
    stim.push_back(entryT'{OpRead,  16'h225c, 4'h0, 32'h0,        1'b0, 0, "rdMergeOther"});
    stim.push_back(entryT'{OpRead,  16'h3234, 4'h0, 32'h0,        1'b1, 4, "evictDirty"});
    stim.push_back(entryT'{OpRead,  16'h1234, 4'h0, 32'h0,        1'b1, 0, "rdBackVictim"});
    stim.push_back(entryT'{OpWrite, 16'h4470, 4'hc, 32'hcafef00d, 1'b1, 0, "stMissSet7"});
    stim.push_back(entryT'{OpWrite, 16'h2254, 4'h3, 32'h0000a5a5, 1'b0, 0, "wrHitSet5"});
    stim.push_back(entryT'{OpFlush, 16'h0000, 4'h0, 32'h0,        1'b0, 8, "flushDirty"});
    stim.push_back(entryT'{OpFlush, 16'h0000, 4'h0, 32'h0,        1'b0, 0, "flushClean"});
    stim.push_back(entryT'{OpRead,  16'h1234, 4'h0, 32'h0,        1'b0, 0, "rdBeforeInval"});
    stim.push_back(entryT'{OpInval, 16'h0000, 4'h0, 32'h0,        1'b0, 0, "invalidate"});
    stim.push_back(entryT'{OpRead,  16'h1234, 4'h0, 32'h0,        1'b1, 0, "rdAfterInval"});
    stim.push_back(entryT'{OpRead,  16'h2254, 4'h0, 32'h0,        1'b1, 0, "rdAfterInval2"});
    cycleLimit = stim.size() * 60;
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;
    foreach (stim[i]) begin
      while (cacheBusy) begin         // Previous entry still running
        @(posedge clk);
        #10;
      end
      testName        = stim[i].name;
      expMiss         = stim[i].miss;
      expWbBeats      = stim[i].wb;
      cacheAdr        = stim[i].adr;
      byteMask        = stim[i].mask;
      writeData       = stim[i].data;
      cacheWrite      = (stim[i].op == OpWrite);
      cacheReq        = (stim[i].op == OpRead) || (stim[i].op == OpWrite);
      flushCache      = (stim[i].op == OpFlush);
      invalidateCache = (stim[i].op == OpInval);
      @(posedge clk);
      #10;
      {cacheReq, flushCache, invalidateCache} = 3'b000;  // One-cycle strobes
    end
    while (cacheBusy) begin
      @(posedge clk);
      #10;
    end
    repeat (2) @(posedge clk);
    $display("Tests done %0d of %0d, errors %0d, assertion failures %0d", testCount,
             stim.size(), errorCount, DUT.ctrl.ctrlAsserts.failCount);
    if (errorCount == 0 && testCount == stim.size() &&
        DUT.ctrl.ctrlAsserts.failCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
